// File: compile.f
rtl/kdi_pkg.sv
rtl/kdi_ctrl_if.sv
rtl/kdi_req_decode.sv
rtl/kdi_fsm.sv
rtl/kdi_key_regs.sv
rtl/otp_kdi_top.sv
test/kdi_fsm_sva.sv
test/kdi_checker.sv
test/tb_kdi.sv

// File: run.sh
#!/bin/sh
# Build and run the key derivation testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_kdi \
  -f compile.f -Mdir obj_dir -o vsim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: test/tb_kdi.sv
// Testbench top for the key derivation unit, with digest and EDN models,
// LFSR stimulus, the checker and the bound FSM assertions
`timescale 1ns/100ps
`default_nettype none

module tb_kdi import kdi_pkg::*; ();

  localparam logic [KeyWidth-1:0]   KeyInit   = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
  localparam logic [NonceWidth-1:0] NonceInit = 128'ha5a5_0f0f_c3c3_9696_5a5a_f0f0_3c3c_6969;
  // 12 requests of at most about 200 cycles plus margin
  localparam int TimeoutCycles = 3000;

  logic                    clk_i, rst_ni, kdi_en_i;
  logic [NumReq-1:0]       key_req_i, key_ack_o, pending;
  logic [4*BlockWidth-1:0] flash_data_seed_i, flash_addr_seed_i;
  logic [2*BlockWidth-1:0] otbn_seed_i;
  logic                    seed_valid_i, edn_req_o, edn_ack_i;
  logic [BlockWidth-1:0]   edn_data_i, scrmbl_data_o, scrmbl_data_i, blk, acc, result;
  logic [1:0]              scrmbl_cmd_o, scrmbl_sel_o, cmd;
  logic                    scrmbl_valid_o, scrmbl_ready_i, scrmbl_valid_i, fire, bp_en;
  logic [KeyWidth-1:0]     key_o;
  logic [NonceWidth-1:0]   nonce_o;
  logic                    seed_valid_o;
  logic [31:0]             lfsr_q;
  int                      cycles, lat, edn_wait, checks, errors;

  ////////////////////////////////////////////////////////////////////////////
  // Random source

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rnd(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  always #5 clk_i = ~clk_i;

  // Cycle limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Digest datapath model that XOR-folds with rotation
  // Result comes back 2 to 5 cycles after finalize

  always @(posedge clk_i) begin
    fire = scrmbl_valid_o && scrmbl_ready_i;
    cmd  = scrmbl_cmd_o;
    blk  = scrmbl_data_o;
    #1;
    scrmbl_valid_i = 1'b0;
    if (lat > 0) begin
      lat--;
      if (lat == 0) begin
        scrmbl_valid_i = 1'b1;
        scrmbl_data_i  = result;
      end
    end
    if (fire && rst_ni) begin
      case (cmd)
        2'd1: acc = '0;
        2'd3: begin
          result = acc ^ (64'h9e37_79b9_7f4a_7c15 * 64'(scrmbl_sel_o + 2'd1));
          lat    = 2 + int'(rnd(2));
        end
        default: acc = {acc[56:0], acc[63:57]} ^ blk;
      endcase
    end
    scrmbl_ready_i = bp_en ? (rnd(2) != 0) : 1'b1;
  end

  // EDN model giving one word per ack after a random gap
  always @(posedge clk_i) begin
    #1;
    if (edn_ack_i) begin
      edn_ack_i = 1'b0;
    end else if (edn_req_o) begin
      if (edn_wait == 0) begin
        edn_ack_i  = 1'b1;
        edn_data_i = rnd(64);
        edn_wait   = bp_en ? int'(rnd(2)) : 0;
      end else begin
        edn_wait--;
      end
    end
  end

  otp_kdi_top #(
    .KeyInit   (KeyInit),
    .NonceInit (NonceInit)
  ) dut_i (.*);

  kdi_checker #(
    .KeyInit   (KeyInit),
    .NonceInit (NonceInit)
  ) u_checker (
    .*,
    .checks_o (checks),
    .errors_o (errors)
  );

  bind kdi_fsm kdi_fsm_sva u_fsm_sva (.*);

  // Raise the requests in mask and wait for all of their acks
  task automatic run_req(input logic [NumReq-1:0] mask, input logic sv, input logic bp);
    flash_data_seed_i = {rnd(64), rnd(64), rnd(64), rnd(64)};
    flash_addr_seed_i = {rnd(64), rnd(64), rnd(64), rnd(64)};
    otbn_seed_i       = {rnd(64), rnd(64)};
    seed_valid_i      = sv;
    bp_en             = bp;
    pending           = mask;
    key_req_i         = mask;
    while (pending != '0) begin
      @(posedge clk_i);
      if (key_ack_o != '0) begin
        pending = pending & ~key_ack_o;
        #1;
        key_req_i = pending;
      end
    end
  endtask

  initial begin
    lfsr_q = 32'd87261;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    kdi_en_i = 1'b0;
    key_req_i = '0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    otbn_seed_i = '0;
    seed_valid_i = 1'b0;
    edn_ack_i = 1'b0;
    edn_data_i = '0;
    scrmbl_ready_i = 1'b1;
    scrmbl_valid_i = 1'b0;
    scrmbl_data_i = '0;
    bp_en = 1'b0;
    acc = '0;
    result = '0;
    cycles = 0;
    lat = 0;
    edn_wait = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    kdi_en_i = 1'b1;
    @(posedge clk_i);
    #1;
    kdi_en_i = 1'b0;
    run_req(3'b001, 1'b1, 1'b0);
    run_req(3'b010, 1'b1, 1'b0);
    run_req(3'b100, 1'b1, 1'b0);
    run_req(3'b001, 1'b0, 1'b0);
    run_req(3'b100, 1'b0, 1'b0);
    run_req(3'b111, 1'b1, 1'b0);
    run_req(3'b111, 1'b1, 1'b1);
    run_req(3'b010, 1'b1, 1'b1);
    repeat (3) @(posedge clk_i);
    $display("Tests checked: %0d, failing: %0d", checks, errors);
    // Reset values plus twelve requests
    if (errors == 0 && checks == 13) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_kdi

`default_nettype wire

// File: test/kdi_checker.sv
// Watches the top-level ports of the DUT and compares key, nonce and
// seed-valid after reset and at every ack against the reference model
`timescale 1ns/100ps
`default_nettype none

module kdi_checker import kdi_pkg::*; #(
  parameter logic [KeyWidth-1:0]   KeyInit   = '0,
  parameter logic [NonceWidth-1:0] NonceInit = '0
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic [NumReq-1:0]       key_req_i,
  input  wire logic [NumReq-1:0]       key_ack_o,
  input  wire logic [4*BlockWidth-1:0] flash_data_seed_i,
  input  wire logic [4*BlockWidth-1:0] flash_addr_seed_i,
  input  wire logic [2*BlockWidth-1:0] otbn_seed_i,
  input  wire logic                    seed_valid_i,
  input  wire logic                    edn_req_o,
  input  wire logic                    edn_ack_i,
  input  wire logic [BlockWidth-1:0]   edn_data_i,
  input  wire logic [KeyWidth-1:0]     key_o,
  input  wire logic [NonceWidth-1:0]   nonce_o,
  input  wire logic                    seed_valid_o,
  output int                           checks_o,
  output int                           errors_o
);

  logic [BlockWidth-1:0]   edn_q[$];
  logic [NonceWidth-1:0]   exp_nonce;
  logic [KeyWidth-1:0]     exp_key;
  logic [4*BlockWidth-1:0] seeds;
  logic [BlockWidth-1:0]   e0, e1, e2, e3;
  logic                    init_pending;
  int                      ptr, win, exp_win, n_edn, fails;
  string                   name;

  // Constant mixed in by the digest for each constant set
  function automatic logic [63:0] salt(logic [1:0] sel);
    return 64'h9e37_79b9_7f4a_7c15 * 64'(sel + 2'd1);
  endfunction

  // One key half as a rotate by 7 and XOR for every absorbed block
  function automatic logic [63:0] ref_half(logic [63:0] b0, logic [63:0] b1, logic ent,
                                           logic [63:0] x0, logic [63:0] x1,
                                           logic [1:0] sel);
    logic [63:0] acc;
    acc = {57'd0, 7'd0};
    acc = {acc[56:0], acc[63:57]} ^ b0;
    acc = {acc[56:0], acc[63:57]} ^ b1;
    if (ent) begin
      acc = {acc[56:0], acc[63:57]} ^ x0;
      acc = {acc[56:0], acc[63:57]} ^ x1;
    end
    return acc ^ salt(sel);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison after reset and at each ack

  always @(posedge clk_i or negedge rst_ni) begin : p_compare
    if (!rst_ni) begin
      edn_q.delete();
      exp_nonce    = NonceInit;
      init_pending = 1'b1;
      ptr          = 0;
      checks_o     = 0;
      errors_o     = 0;
    end else begin
      // Output registers must still hold their reset values
      if (init_pending) begin
        init_pending = 1'b0;
        fails        = 0;
        checks_o     = checks_o + 1;
        if (key_o !== KeyInit) begin
          $display("FAILED reset key expected %h actual %h", KeyInit, key_o);
          fails++;
        end
        if (nonce_o !== NonceInit) begin
          $display("FAILED reset nonce expected %h actual %h", NonceInit, nonce_o);
          fails++;
        end
        if (seed_valid_o !== 1'b0) begin
          $display("FAILED reset seed_valid expected 0 actual %b", seed_valid_o);
          fails++;
        end
        if (fails == 0) $display("ok     reset");
        if (fails != 0) errors_o = errors_o + 1;
      end
      if (edn_req_o && edn_ack_i) edn_q.push_back(edn_data_i);
      if (key_ack_o != '0) begin
        fails    = 0;
        checks_o = checks_o + 1;
        win      = key_ack_o[0] ? 0 : (key_ack_o[1] ? 1 : 2);
        name     = $sformatf("%s#%0d", win == 0 ? "flash_data" :
                             (win == 1 ? "flash_addr" : "otbn"), checks_o);
        if (!$onehot(key_ack_o)) begin
          $display("%s: more than one requester acknowledged at once", name);
          fails++;
        end
        // Round robin from the pointer over the still pending requests
        exp_win = -1;
        for (int i = 0; i < NumReq; i++) begin
          if (exp_win < 0 && key_req_i[(ptr + i) % NumReq]) exp_win = (ptr + i) % NumReq;
        end
        if (exp_win != win) begin
          $display("FAILED %s winner expected %0d actual %0d", name, exp_win, win);
          fails++;
        end
        ptr   = (win + 1) % NumReq;
        n_edn = (win == 0) ? 2 : ((win == 1) ? 1 : 6);
        if (edn_q.size() != n_edn) begin
          $display("%s: saw %0d EDN words instead of %0d", name, edn_q.size(), n_edn);
          fails++;
        end else begin
          seeds = (win == 0) ? flash_data_seed_i :
                  (win == 1) ? flash_addr_seed_i : {otbn_seed_i, otbn_seed_i};
          if (!seed_valid_i) seeds = '0;
          {e0, e1, e2, e3} = (win == 2) ? {edn_q[0], edn_q[1], edn_q[2], edn_q[3]} : '0;
          exp_key[63:0]   = ref_half(seeds[63:0], seeds[127:64], win == 2, e0, e1, 2'(win));
          exp_key[127:64] = ref_half(seeds[191:128], seeds[255:192], win == 2, e2, e3,
                                     2'(win));
          // Nonce holds the last fetched words
          // Word 1 changes only when two were taken
          exp_nonce[63:0] = edn_q[n_edn - 2 + (win == 1 ? 1 : 0)];
          if (win != 1) exp_nonce[127:64] = edn_q[n_edn - 1];
          if (key_o !== exp_key) begin
            $display("FAILED %s key expected %h actual %h", name, exp_key, key_o);
            fails++;
          end
          if (nonce_o !== exp_nonce) begin
            $display("FAILED %s nonce expected %h actual %h", name, exp_nonce, nonce_o);
            fails++;
          end
          if (seed_valid_o !== seed_valid_i) begin
            $display("FAILED %s seed_valid expected %b actual %b", name, seed_valid_i,
                     seed_valid_o);
            fails++;
          end
        end
        edn_q.delete();
        if (fails == 0) $display("ok     %s", name);
        if (fails != 0) errors_o = errors_o + 1;
      end
    end
  end

endmodule : kdi_checker

`default_nettype wire

// File: test/kdi_fsm_sva.sv
// Protocol assertions for the sequencing FSM, bound into kdi_fsm by the
// testbench top
`timescale 1ns/100ps
`default_nettype none

module kdi_fsm_sva (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic       edn_req_o,
  input wire logic       edn_ack_i,
  input wire logic [1:0] scrmbl_cmd_o,
  input wire logic       scrmbl_valid_o,
  input wire logic       scrmbl_ready_i,
  input wire logic       scrmbl_valid_i
);

  // Set by an accepted finalize, cleared when the result returns
  logic fin_pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fin
    if (!rst_ni) begin
      fin_pending_q <= 1'b0;
    end else if (scrmbl_valid_i) begin
      fin_pending_q <= 1'b0;
    end else if (scrmbl_valid_o && scrmbl_ready_i && scrmbl_cmd_o == 2'd3) begin
      fin_pending_q <= 1'b1;
    end
  end

  default disable iff (!rst_ni);

  // EDN request is a level that only the ack may drop
  a_edn_hold: assert property (@(posedge clk_i) edn_req_o && !edn_ack_i |=> edn_req_o)
    else $error("edn_req_o dropped before edn_ack_i");

  // Back-pressure freezes the offered block
  a_bp_hold: assert property (@(posedge clk_i)
    scrmbl_valid_o && !scrmbl_ready_i |=> scrmbl_valid_o && $stable(scrmbl_cmd_o))
    else $error("scrmbl command changed while ready was low");

  // Nothing new goes out while a digest result is outstanding
  a_fin_quiet: assert property (@(posedge clk_i) fin_pending_q |-> !scrmbl_valid_o)
    else $error("scrmbl_valid_o raised before the digest result returned");

endmodule : kdi_fsm_sva

`default_nettype wire

// File: rtl/otp_kdi_top.sv
// Top level of the OTP scrambling-key derivation unit. Connects the
// request arbiter, the sequencing FSM and the output registers
`timescale 1ns/100ps
`default_nettype none

module otp_kdi_top import kdi_pkg::*; #(
  parameter logic [KeyWidth-1:0]   KeyInit   = 128'h3a5f_c6e1_0b94_d278_6f13_a8c0_5e2d_b947,
  parameter logic [NonceWidth-1:0] NonceInit = 128'h9c27_e4b1_5d80_3f6a_c1e8_2b7d_0a46_f593
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    kdi_en_i,
  // Requesters
  input  logic [NumReq-1:0]       key_req_i,
  output logic [NumReq-1:0]       key_ack_o,
  // Seeds from OTP
  input  logic [4*BlockWidth-1:0] flash_data_seed_i,
  input  logic [4*BlockWidth-1:0] flash_addr_seed_i,
  input  logic [2*BlockWidth-1:0] otbn_seed_i,
  input  logic                    seed_valid_i,
  // EDN
  output logic                    edn_req_o,
  input  logic                    edn_ack_i,
  input  logic [BlockWidth-1:0]   edn_data_i,
  // Digest datapath
  output scrmbl_cmd_e             scrmbl_cmd_o,
  output digest_sel_e             scrmbl_sel_o,
  output logic [BlockWidth-1:0]   scrmbl_data_o,
  output logic                    scrmbl_valid_o,
  input  logic                    scrmbl_ready_i,
  input  logic                    scrmbl_valid_i,
  input  logic [BlockWidth-1:0]   scrmbl_data_i,
  // Derived key material
  output logic [KeyWidth-1:0]     key_o,
  output logic [NonceWidth-1:0]   nonce_o,
  output logic                    seed_valid_o
);

  logic     req_valid, req_done;
  req_cfg_t req_cfg;

  kdi_ctrl_if ctrl_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Decode, execute and result stages

  kdi_req_decode u_req_decode (
    .clk_i, .rst_ni, .key_req_i,
    .flash_data_seed_i, .flash_addr_seed_i, .otbn_seed_i, .seed_valid_i,
    .key_ack_o,
    .req_done_i  (req_done),
    .req_valid_o (req_valid),
    .req_cfg_o   (req_cfg)
  );

  kdi_fsm u_fsm (
    .clk_i, .rst_ni, .kdi_en_i,
    .req_valid_i (req_valid),
    .req_cfg_i   (req_cfg),
    .req_done_o  (req_done),
    .edn_req_o, .edn_ack_i,
    .scrmbl_cmd_o, .scrmbl_sel_o, .scrmbl_valid_o, .scrmbl_ready_i, .scrmbl_valid_i,
    .ctrl        (ctrl_if.fsm)
  );

  kdi_key_regs #(
    .KeyInit   (KeyInit),
    .NonceInit (NonceInit)
  ) u_key_regs (
    .clk_i, .rst_ni,
    .ctrl      (ctrl_if.regs),
    .req_cfg_i (req_cfg),
    .scrmbl_data_i, .edn_data_i, .scrmbl_data_o,
    .key_o, .nonce_o, .seed_valid_o
  );

endmodule : otp_kdi_top

`default_nettype wire

// File: rtl/kdi_key_regs.sv
// Key, nonce and seed-valid output registers of the derivation unit, and
// the mux that picks the block sent to the digest datapath
`timescale 1ns/100ps
`default_nettype none

module kdi_key_regs import kdi_pkg::*; #(
  parameter logic [KeyWidth-1:0]   KeyInit   = '0,
  parameter logic [NonceWidth-1:0] NonceInit = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  kdi_ctrl_if.regs              ctrl,
  input  req_cfg_t              req_cfg_i,
  input  logic [BlockWidth-1:0] scrmbl_data_i,
  input  logic [BlockWidth-1:0] edn_data_i,
  output logic [BlockWidth-1:0] scrmbl_data_o,
  output logic [KeyWidth-1:0]   key_o,
  output logic [NonceWidth-1:0] nonce_o,
  output logic                  seed_valid_o
);

  logic [KeyWidth/BlockWidth-1:0][BlockWidth-1:0]   key_q;
  logic [NonceWidth/BlockWidth-1:0][BlockWidth-1:0] nonce_q;
  logic                                             seed_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_out_regs
    if (!rst_ni) begin
      key_q        <= KeyInit;
      nonce_q      <= NonceInit;
      seed_valid_q <= 1'b0;
    end else begin
      // Half 0 from seed blocks 0-1, half 1 from blocks 2-3
      if (ctrl.key_we) key_q[ctrl.seed_idx[1]] <= scrmbl_data_i;
      if (ctrl.nonce_we) nonce_q[ctrl.entropy_idx[0]] <= edn_data_i;
      if (ctrl.seed_valid_we) seed_valid_q <= req_cfg_i.seed_valid;
    end
  end

  // Entropy words come back out of the nonce register
  // An invalid seed goes to the digest as zeros
  assign scrmbl_data_o = ctrl.entropy_sel    ? nonce_q[ctrl.entropy_idx[0]] :
                         req_cfg_i.seed_valid ? req_cfg_i.seed[ctrl.seed_idx] : '0;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

endmodule : kdi_key_regs

`default_nettype wire

// File: rtl/kdi_fsm.sv
// Sequencing FSM of the key derivation, runs the digest twice per request
// and fetches entropy and nonce words from EDN
`timescale 1ns/100ps
`default_nettype none

module kdi_fsm import kdi_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        kdi_en_i,
  input  logic        req_valid_i,
  input  req_cfg_t    req_cfg_i,
  output logic        req_done_o,
  output logic        edn_req_o,
  input  logic        edn_ack_i,
  output scrmbl_cmd_e scrmbl_cmd_o,
  output digest_sel_e scrmbl_sel_o,
  output logic        scrmbl_valid_o,
  input  logic        scrmbl_ready_i,
  input  logic        scrmbl_valid_i,
  kdi_ctrl_if.fsm     ctrl
);

  typedef enum logic [3:0] {
    ResetSt, IdleSt, ClrSt, LoadSt, FetchEntropySt,
    DigEntropySt, FinSt, WaitSt, FetchNonceSt, FinishSt
  } state_e;

  state_e     state_d, state_q;
  logic       seed_cnt_clr, seed_cnt_en, entropy_cnt_clr, entropy_cnt_en;
  logic [1:0] seed_cnt_q, entropy_cnt_q;
  logic       edn_req_d, edn_req_q, edn_got;

  // Only an ack to a pending request counts
  assign edn_got   = edn_req_q & edn_ack_i;
  assign edn_req_o = edn_req_q;

  assign ctrl.seed_idx    = seed_cnt_q;
  assign ctrl.entropy_idx = entropy_cnt_q;
  assign scrmbl_sel_o     = req_cfg_i.digest_sel;

  always_comb begin : p_fsm
    state_d          = state_q;
    seed_cnt_clr     = 1'b0;
    seed_cnt_en      = 1'b0;
    entropy_cnt_clr  = 1'b0;
    entropy_cnt_en   = 1'b0;
    // Request level holds until its ack
    edn_req_d        = edn_req_q & ~edn_ack_i;
    ctrl.key_we        = 1'b0;
    ctrl.nonce_we      = 1'b0;
    ctrl.seed_valid_we = 1'b0;
    ctrl.entropy_sel   = 1'b0;
    scrmbl_cmd_o     = LoadShadow;
    scrmbl_valid_o   = 1'b0;
    req_done_o       = 1'b0;

    unique case (state_q)
      ResetSt: begin
        if (kdi_en_i) state_d = IdleSt;
      end
      IdleSt: begin
        if (req_valid_i) begin
          state_d         = ClrSt;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Back to the initial digest state for each half
      ClrSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = DigestInit;
        if (scrmbl_ready_i) state_d = LoadSt;
      end
      // Odd seed block triggers the digest round
      LoadSt: begin
        scrmbl_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d = req_cfg_i.ingest_entropy ? FetchEntropySt : FinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Two EDN words, parked in the nonce register
      FetchEntropySt: begin
        edn_req_d = ~edn_got;
        if (edn_got) begin
          ctrl.nonce_we = 1'b1;
          if (entropy_cnt_q == 2'd1) begin
            state_d         = DigEntropySt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      DigEntropySt: begin
        scrmbl_valid_o   = 1'b1;
        ctrl.entropy_sel = 1'b1;
        if (entropy_cnt_q[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d         = FinSt;
            entropy_cnt_clr = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      FinSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = DigestFinalize;
        if (scrmbl_ready_i) state_d = WaitSt;
      end
      // Result lands in the half given by seed_cnt[1]
      WaitSt: begin
        if (scrmbl_valid_i) begin
          ctrl.key_we = 1'b1;
          if (seed_cnt_q == 2'd1) begin
            seed_cnt_en = 1'b1;
            state_d     = ClrSt;
          end else begin
            seed_cnt_clr       = 1'b1;
            ctrl.seed_valid_we = 1'b1;
            state_d            = FetchNonceSt;
          end
        end
      end
      // Words 0 up to nonce_last are refreshed
      FetchNonceSt: begin
        edn_req_d = ~edn_got;
        if (edn_got) begin
          ctrl.nonce_we = 1'b1;
          if (entropy_cnt_q == 2'(req_cfg_i.nonce_last)) begin
            state_d         = FinishSt;
            entropy_cnt_clr = 1'b1;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      FinishSt: begin
        req_done_o = 1'b1;
        state_d    = IdleSt;
      end
      default: state_d = ResetSt;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= ResetSt;
      edn_req_q     <= 1'b0;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      if (seed_cnt_clr) seed_cnt_q <= '0;
      else if (seed_cnt_en) seed_cnt_q <= seed_cnt_q + 2'd1;
      if (entropy_cnt_clr) entropy_cnt_q <= '0;
      else if (entropy_cnt_en) entropy_cnt_q <= entropy_cnt_q + 2'd1;
    end
  end

endmodule : kdi_fsm

`default_nettype wire

// File: rtl/kdi_req_decode.sv
// Round-robin arbitration of the three key requests, and mapping of the
// winner onto its configuration. The winner stays locked until done
`timescale 1ns/100ps
`default_nettype none

module kdi_req_decode import kdi_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NumReq-1:0]       key_req_i,
  input  logic [4*BlockWidth-1:0] flash_data_seed_i,
  input  logic [4*BlockWidth-1:0] flash_addr_seed_i,
  input  logic [2*BlockWidth-1:0] otbn_seed_i,
  input  logic                    seed_valid_i,
  output logic [NumReq-1:0]       key_ack_o,
  input  logic                    req_done_i,
  output logic                    req_valid_o,
  output req_cfg_t                req_cfg_o
);

  localparam int IdxW = $clog2(NumReq);

  logic            busy_q;
  logic [IdxW-1:0] ptr_q, winner_q, pick, ptr_next;
  logic            found;
  req_cfg_t        cfg [NumReq];

  ////////////////////////////////////////////////////////////////////////////
  // Per-requester configuration

  // Flash data key, two nonce words
  assign cfg[0] = '{ingest_entropy: 1'b0, digest_sel: FlashDataKey,
                    nonce_last: 1'b1, seed_valid: seed_valid_i,
                    seed: flash_data_seed_i};
  // Flash address key, single nonce word
  assign cfg[1] = '{ingest_entropy: 1'b0, digest_sel: FlashAddrKey,
                    nonce_last: 1'b0, seed_valid: seed_valid_i,
                    seed: flash_addr_seed_i};
  // OTBN mixes in entropy, the 128 bit seed feeds both halves
  assign cfg[2] = '{ingest_entropy: 1'b1, digest_sel: SramDataKey,
                    nonce_last: 1'b1, seed_valid: seed_valid_i,
                    seed: {otbn_seed_i, otbn_seed_i}};

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration

  // First active request at or after the pointer
  always_comb begin : p_arb
    int cand;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < NumReq; i++) begin
      cand = (int'(ptr_q) + i) % NumReq;
      if (!found && key_req_i[cand]) begin
        found = 1'b1;
        pick  = IdxW'(cand);
      end
    end
  end

  // Pointer moves just past the served requester
  assign ptr_next = (winner_q == IdxW'(NumReq - 1)) ? '0 : winner_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lock
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      ptr_q    <= '0;
      winner_q <= '0;
    end else if (req_done_i) begin
      busy_q <= 1'b0;
      ptr_q  <= ptr_next;
    end else if (!busy_q && found) begin
      busy_q   <= 1'b1;
      winner_q <= pick;
    end
  end

  assign req_valid_o = busy_q;
  assign req_cfg_o   = cfg[winner_q];

  // Ack goes out together with the done strobe
  always_comb begin : p_ack
    key_ack_o = '0;
    if (req_done_i) begin
      key_ack_o[winner_q] = 1'b1;
    end
  end

endmodule : kdi_req_decode

`default_nettype wire

// File: rtl/kdi_ctrl_if.sv
// Control bundle from the sequencing FSM to the key and nonce registers.
// The FSM drives all fields, the register block only reads them
`timescale 1ns/100ps
`default_nettype none

interface kdi_ctrl_if ();

  // Register write strobes
  logic       key_we;
  logic       nonce_we;
  logic       seed_valid_we;
  // High while entropy words are sent to the digest
  logic       entropy_sel;
  // Seed block index, bit 1 is the key half
  logic [1:0] seed_idx;
  // EDN word index
  logic [1:0] entropy_idx;

  modport fsm (
    output key_we, nonce_we, seed_valid_we, entropy_sel, seed_idx, entropy_idx
  );

  modport regs (
    input key_we, nonce_we, seed_valid_we, entropy_sel, seed_idx, entropy_idx
  );

endinterface : kdi_ctrl_if

`default_nettype wire

// File: rtl/kdi_pkg.sv
// Shared widths, digest command encodings and the request configuration
// used by the OTP scrambling-key derivation unit
`default_nettype none

package kdi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  // One digest block and one EDN word
  parameter int BlockWidth = 64;
  // Key is two digest results
  parameter int KeyWidth   = 2 * BlockWidth;
  // Nonce register holds two EDN words
  parameter int NonceWidth = 2 * BlockWidth;
  // 0 flash data key, 1 flash address key, 2 OTBN key
  parameter int NumReq     = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Digest datapath encodings

  typedef enum logic [1:0] {
    LoadShadow     = 2'd0,
    DigestInit     = 2'd1,
    Digest         = 2'd2,
    DigestFinalize = 2'd3
  } scrmbl_cmd_e;

  // Constant set used by the digest, OTBN shares the SRAM set
  typedef enum logic [1:0] {
    FlashDataKey = 2'd0,
    FlashAddrKey = 2'd1,
    SramDataKey  = 2'd2
  } digest_sel_e;

  // Everything the FSM needs to know about the granted request
  typedef struct packed {
    logic                       ingest_entropy;
    digest_sel_e                digest_sel;
    logic                       nonce_last;
    logic                       seed_valid;
    logic [3:0][BlockWidth-1:0] seed;
  } req_cfg_t;

endpackage : kdi_pkg

`default_nettype wire
